//--- hw/dl_pkg.sv
package dl_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  typedef logic [31:0] dl_word_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [22:0] vram_adr_t;
  typedef logic [9:0]  coord_t;
  typedef logic [10:0] dst_coord_t;
  typedef logic [31:0] color_t;
  typedef logic [1:0]  word_idx_t;

  // header opcodes
  localparam opcode_t OP_NOP         = 8'h00;
  localparam opcode_t OP_EODL        = 8'h0F;
  localparam opcode_t OP_SETFRAME    = 8'h20;
  localparam opcode_t OP_SETDRAWAREA = 8'h21;
  localparam opcode_t OP_SETFCOLOR   = 8'h23;
  localparam opcode_t OP_PATBLT      = 8'h81;
  localparam opcode_t OP_BITBLT      = 8'h82;

  // field positions inside a word
  localparam int OPCODE_LSB   = 24;
  localparam int HI_FIELD_LSB = 16;
  localparam int LO_FIELD_LSB = 0;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_HDR,
    SEQ_ARG1,
    SEQ_ARG2,
    SEQ_ARG3
  } seq_state_e;

  // ------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------
  typedef struct packed {
    logic pixel;
    logic add;
    logic interr;
  } busy_t;

  typedef struct packed {
    logic      take;
    opcode_t   opcode;
    word_idx_t idx;
    dl_word_t  data;
  } dl_step_t;

  typedef struct packed {
    vram_adr_t vram_adr;
    coord_t    width;
    coord_t    height;
  } frame_cfg_t;

  typedef struct packed {
    coord_t pos_x;
    coord_t pos_y;
    coord_t siz_x;
    coord_t siz_y;
  } draw_area_t;

  typedef struct packed {
    dst_coord_t dpos_x;
    dst_coord_t dpos_y;
    coord_t     dsiz_x;
    coord_t     dsiz_y;
  } blit_rect_t;

  typedef struct packed {
    blit_rect_t rect;
    coord_t     spos_x;
    coord_t     spos_y;
  } bitblt_cmd_t;

  // ------------------------------------------------------------
  // field extraction
  // ------------------------------------------------------------
  function automatic opcode_t get_opcode(dl_word_t w);
    return w[OPCODE_LSB +: $bits(opcode_t)];
  endfunction

  function automatic vram_adr_t get_vram_adr(dl_word_t w);
    return w[LO_FIELD_LSB +: $bits(vram_adr_t)];
  endfunction

  function automatic coord_t get_hi_coord(dl_word_t w);
    return w[HI_FIELD_LSB +: $bits(coord_t)];
  endfunction

  function automatic coord_t get_lo_coord(dl_word_t w);
    return w[LO_FIELD_LSB +: $bits(coord_t)];
  endfunction

  function automatic dst_coord_t get_hi_dst(dl_word_t w);
    return w[HI_FIELD_LSB +: $bits(dst_coord_t)];
  endfunction

  function automatic dst_coord_t get_lo_dst(dl_word_t w);
    return w[LO_FIELD_LSB +: $bits(dst_coord_t)];
  endfunction

  // index of the last word of a command (0 for one-word commands)
  function automatic word_idx_t cmd_last_idx(opcode_t op);
    case (op)
      OP_SETFRAME, OP_SETDRAWAREA, OP_PATBLT: return 2'd2;
      OP_SETFCOLOR: return 2'd1;
      OP_BITBLT: return 2'd3;
      default: return 2'd0;
    endcase
  endfunction

endpackage

//--- hw/dl_sequencer.sv
`timescale 1ns/1ps

module dl_sequencer (
  input  logic             CLK,
  input  logic             RST_X,
  input  logic             init,
  input  logic             exe,
  input  dl_pkg::busy_t    busy,
  input  dl_pkg::dl_word_t buf_data,
  input  logic             empty,
  output logic             buf_rd,
  output dl_pkg::dl_step_t step
);

  logic                 exe_valid;
  logic                 any_busy;
  logic                 executable;
  logic                 take;
  logic                 stg_vld;
  dl_pkg::dl_word_t     stg_data;
  dl_pkg::opcode_t      cmd_op;
  dl_pkg::opcode_t      cur_op;
  dl_pkg::word_idx_t    cur_idx;
  dl_pkg::seq_state_e   state;
  dl_pkg::seq_state_e   adv_state;

  // ------------------------------------------------------------
  // exe latch and read control
  // ------------------------------------------------------------
  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      exe_valid <= 1'b0;
    end else if (init) begin
      exe_valid <= 1'b0;
    end else if (exe) begin
      exe_valid <= 1'b1;
    end
  end

  assign any_busy   = |busy;
  assign executable = exe_valid & ~any_busy;
  assign buf_rd     = ~empty & executable;
  assign take       = stg_vld & executable;

  // staging word is held while stalled
  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      stg_vld <= 1'b0;
    end else if (init) begin
      stg_vld <= 1'b0;
    end else if (executable) begin
      stg_vld <= buf_rd;
    end
  end

  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      stg_data <= '0;
    end else if (init) begin
      stg_data <= '0;
    end else if (buf_rd) begin
      stg_data <= buf_data;
    end
  end

  // ------------------------------------------------------------
  // word index FSM
  // ------------------------------------------------------------
  always_comb begin
    case (state)
      dl_pkg::SEQ_ARG1: cur_idx = 2'd1;
      dl_pkg::SEQ_ARG2: cur_idx = 2'd2;
      dl_pkg::SEQ_ARG3: cur_idx = 2'd3;
      default:          cur_idx = 2'd0;
    endcase
  end

  // header carries its own code, arguments use the latched one
  assign cur_op = (state == dl_pkg::SEQ_HDR) ? dl_pkg::get_opcode(stg_data) : cmd_op;

  always_comb begin
    case (state)
      dl_pkg::SEQ_HDR:  adv_state = dl_pkg::SEQ_ARG1;
      dl_pkg::SEQ_ARG1: adv_state = dl_pkg::SEQ_ARG2;
      dl_pkg::SEQ_ARG2: adv_state = dl_pkg::SEQ_ARG3;
      default:          adv_state = dl_pkg::SEQ_HDR;
    endcase
  end

  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      state  <= dl_pkg::SEQ_IDLE;
      cmd_op <= dl_pkg::OP_NOP;
    end else if (init) begin
      state  <= dl_pkg::SEQ_IDLE;
      cmd_op <= dl_pkg::OP_NOP;
    end else if (state == dl_pkg::SEQ_IDLE) begin
      if (executable) begin
        state <= dl_pkg::SEQ_HDR;
      end
    end else if (take) begin
      cmd_op <= cur_op;
      if (cur_idx == dl_pkg::cmd_last_idx(cur_op)) begin
        state <= dl_pkg::SEQ_HDR;
      end else begin
        state <= adv_state;
      end
    end
  end

  always_comb begin
    step.take   = take;
    step.opcode = cur_op;
    step.idx    = cur_idx;
    step.data   = stg_data;
  end

endmodule

//--- hw/render_state_regs.sv
`timescale 1ns/1ps

module render_state_regs (
  input  logic               CLK,
  input  logic               RST_X,
  input  logic               init,
  input  dl_pkg::dl_step_t   step,
  output dl_pkg::frame_cfg_t frame,
  output dl_pkg::draw_area_t draw_area,
  output dl_pkg::color_t     fcolor
);

  // ------------------------------------------------------------
  // render state written from argument words
  // ------------------------------------------------------------
  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      frame     <= '0;
      draw_area <= '0;
      fcolor    <= '0;
    end else if (init) begin
      frame     <= '0;
      draw_area <= '0;
      fcolor    <= '0;
    end else if (step.take) begin
      case (step.opcode)
        dl_pkg::OP_SETFRAME: begin
          if (step.idx == 2'd1) begin
            frame.vram_adr <= dl_pkg::get_vram_adr(step.data);
          end
          if (step.idx == 2'd2) begin
            frame.width  <= dl_pkg::get_hi_coord(step.data);
            frame.height <= dl_pkg::get_lo_coord(step.data);
          end
        end
        dl_pkg::OP_SETDRAWAREA: begin
          // position first, then size
          if (step.idx == 2'd1) begin
            draw_area.pos_x <= dl_pkg::get_hi_coord(step.data);
            draw_area.pos_y <= dl_pkg::get_lo_coord(step.data);
          end
          if (step.idx == 2'd2) begin
            draw_area.siz_x <= dl_pkg::get_hi_coord(step.data);
            draw_area.siz_y <= dl_pkg::get_lo_coord(step.data);
          end
        end
        dl_pkg::OP_SETFCOLOR: begin
          if (step.idx == 2'd1) begin
            fcolor <= step.data;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hw/blit_launch.sv
`timescale 1ns/1ps

module blit_launch (
  input  logic                CLK,
  input  logic                RST_X,
  input  logic                init,
  input  dl_pkg::dl_step_t    step,
  output dl_pkg::blit_rect_t  pat,
  output dl_pkg::bitblt_cmd_t bit_cmd,
  output logic                ready_pat,
  output logic                ready_bit,
  output logic                start_blt,
  output logic                eodl
);

  logic is_pat;
  logic is_bit;
  logic pat_done;
  logic bit_done;
  logic eodl_hdr;

  assign is_pat   = step.take && (step.opcode == dl_pkg::OP_PATBLT);
  assign is_bit   = step.take && (step.opcode == dl_pkg::OP_BITBLT);
  assign pat_done = is_pat && (step.idx == 2'd2);
  assign bit_done = is_bit && (step.idx == 2'd3);
  assign eodl_hdr = step.take && (step.opcode == dl_pkg::OP_EODL) && (step.idx == 2'd0);

  // ------------------------------------------------------------
  // blit parameters
  // ------------------------------------------------------------
  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      pat     <= '0;
      bit_cmd <= '0;
    end else if (init) begin
      pat     <= '0;
      bit_cmd <= '0;
    end else begin
      if (is_pat && step.idx == 2'd1) begin
        pat.dpos_x <= dl_pkg::get_hi_dst(step.data);
        pat.dpos_y <= dl_pkg::get_lo_dst(step.data);
      end
      if (pat_done) begin
        pat.dsiz_x <= dl_pkg::get_hi_coord(step.data);
        pat.dsiz_y <= dl_pkg::get_lo_coord(step.data);
      end
      if (is_bit && step.idx == 2'd1) begin
        bit_cmd.rect.dpos_x <= dl_pkg::get_hi_dst(step.data);
        bit_cmd.rect.dpos_y <= dl_pkg::get_lo_dst(step.data);
      end
      if (is_bit && step.idx == 2'd2) begin
        bit_cmd.rect.dsiz_x <= dl_pkg::get_hi_coord(step.data);
        bit_cmd.rect.dsiz_y <= dl_pkg::get_lo_coord(step.data);
      end
      // source position rides in the last word
      if (bit_done) begin
        bit_cmd.spos_x <= dl_pkg::get_hi_coord(step.data);
        bit_cmd.spos_y <= dl_pkg::get_lo_coord(step.data);
      end
    end
  end

  // ready pair and pulses
  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      ready_pat <= 1'b0;
      ready_bit <= 1'b0;
      start_blt <= 1'b0;
      eodl      <= 1'b0;
    end else if (init) begin
      ready_pat <= 1'b0;
      ready_bit <= 1'b0;
      start_blt <= 1'b0;
      eodl      <= 1'b0;
    end else begin
      if (pat_done) begin
        ready_pat <= 1'b1;
        ready_bit <= 1'b0;
      end else if (bit_done) begin
        ready_pat <= 1'b0;
        ready_bit <= 1'b1;
      end
      start_blt <= pat_done | bit_done;
      eodl      <= eodl_hdr;
    end
  end

endmodule

//--- hw/dl_decoder.sv
`timescale 1ns/1ps

module dl_decoder (
  input  logic                CLK,
  input  logic                RST_X,
  input  logic                init,
  input  logic                exe,
  input  dl_pkg::busy_t       busy,
  input  dl_pkg::dl_word_t    buf_data,
  input  logic                empty,
  output logic                buf_rd,
  output dl_pkg::frame_cfg_t  frame,
  output dl_pkg::draw_area_t  draw_area,
  output dl_pkg::color_t      fcolor,
  output dl_pkg::blit_rect_t  pat,
  output dl_pkg::bitblt_cmd_t bit_cmd,
  output logic                ready_pat,
  output logic                ready_bit,
  output logic                start_blt,
  output logic                eodl
);

  // one consumed word per take for both decoders
  dl_pkg::dl_step_t step;

  dl_sequencer dl_sequencer_inst (
    .CLK      (CLK),
    .RST_X    (RST_X),
    .init     (init),
    .exe      (exe),
    .busy     (busy),
    .buf_data (buf_data),
    .empty    (empty),
    .buf_rd   (buf_rd),
    .step     (step)
  );

  render_state_regs render_state_regs_inst (
    .CLK       (CLK),
    .RST_X     (RST_X),
    .init      (init),
    .step      (step),
    .frame     (frame),
    .draw_area (draw_area),
    .fcolor    (fcolor)
  );

  blit_launch blit_launch_inst (
    .CLK       (CLK),
    .RST_X     (RST_X),
    .init      (init),
    .step      (step),
    .pat       (pat),
    .bit_cmd   (bit_cmd),
    .ready_pat (ready_pat),
    .ready_bit (ready_bit),
    .start_blt (start_blt),
    .eodl      (eodl)
  );

endmodule

//--- bench/dl_decoder_chk.sv
`timescale 1ns/1ps

module dl_decoder_chk (
  input logic          CLK,
  input logic          RST_X,
  input logic          init,
  input logic          exe,
  input dl_pkg::busy_t busy,
  input logic          empty,
  input logic          buf_rd,
  input logic          start_blt,
  input logic          eodl,
  input logic          ready_pat,
  input logic          ready_bit
);

  int   err_count = 0;
  logic exe_seen;

  // own copy of the exe latch
  always_ff @(posedge CLK or negedge RST_X) begin
    if (!RST_X) begin
      exe_seen <= 1'b0;
    end else if (init) begin
      exe_seen <= 1'b0;
    end else if (exe) begin
      exe_seen <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // protocol rules
  // ------------------------------------------------------------
  rd_gated: assert property (@(posedge CLK) disable iff (!RST_X)
    buf_rd |-> (!empty && busy == '0 && exe_seen))
    else begin
      $error("buf_rd high while empty, busy or before exe");
      err_count = err_count + 1;
    end

  start_single: assert property (@(posedge CLK) disable iff (!RST_X)
    start_blt |=> !start_blt)
    else begin
      $error("start_blt longer than one cycle");
      err_count = err_count + 1;
    end

  eodl_single: assert property (@(posedge CLK) disable iff (!RST_X)
    eodl |=> !eodl)
    else begin
      $error("eodl longer than one cycle");
      err_count = err_count + 1;
    end

  ready_excl: assert property (@(posedge CLK) disable iff (!RST_X)
    !(ready_pat && ready_bit))
    else begin
      $error("ready_pat and ready_bit both high");
      err_count = err_count + 1;
    end

endmodule

//--- bench/dl_decoder_tb.sv
`timescale 1ns/1ps

module dl_decoder_tb;

  localparam int NUM_ROWS    = 11;
  localparam int ROW_TIMEOUT = 400;

  typedef struct {
    int               n;
    dl_pkg::dl_word_t w [4];
    int               start_n;
    int               eodl_n;
    logic             rdy_pat;
    logic             rdy_bit;
  } row_t;

  logic                CLK;
  logic                RST_X;
  logic                init;
  logic                exe;
  dl_pkg::busy_t       busy;
  dl_pkg::dl_word_t    buf_data;
  logic                empty;
  logic                buf_rd;
  dl_pkg::frame_cfg_t  frame;
  dl_pkg::draw_area_t  draw_area;
  dl_pkg::color_t      fcolor;
  dl_pkg::blit_rect_t  pat;
  dl_pkg::bitblt_cmd_t bit_cmd;
  logic                ready_pat;
  logic                ready_bit;
  logic                start_blt;
  logic                eodl;

  dl_pkg::dl_word_t    fifo [$];
  row_t                rows [NUM_ROWS];
  logic [31:0]         rnd;
  logic                last_rd;
  int                  taken;
  int                  start_cnt;
  int                  eodl_cnt;
  dl_pkg::frame_cfg_t  exp_frame;
  dl_pkg::draw_area_t  exp_area;
  dl_pkg::color_t      exp_fcolor;
  dl_pkg::blit_rect_t  exp_pat;
  dl_pkg::bitblt_cmd_t exp_bit;

  dl_decoder dl_decoder_inst (
    .CLK       (CLK),
    .RST_X     (RST_X),
    .init      (init),
    .exe       (exe),
    .busy      (busy),
    .buf_data  (buf_data),
    .empty     (empty),
    .buf_rd    (buf_rd),
    .frame     (frame),
    .draw_area (draw_area),
    .fcolor    (fcolor),
    .pat       (pat),
    .bit_cmd   (bit_cmd),
    .ready_pat (ready_pat),
    .ready_bit (ready_bit),
    .start_blt (start_blt),
    .eodl      (eodl)
  );

  bind dl_decoder dl_decoder_chk dl_decoder_chk_inst (
    .CLK       (CLK),
    .RST_X     (RST_X),
    .init      (init),
    .exe       (exe),
    .busy      (busy),
    .empty     (empty),
    .buf_rd    (buf_rd),
    .start_blt (start_blt),
    .eodl      (eodl),
    .ready_pat (ready_pat),
    .ready_bit (ready_bit)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic row_t mk_row(int n, dl_pkg::dl_word_t w0, dl_pkg::dl_word_t w1,
                                  dl_pkg::dl_word_t w2, dl_pkg::dl_word_t w3,
                                  int start_n, int eodl_n, logic rp, logic rb);
    row_t r;
    r.n       = n;
    r.w[0]    = w0;
    r.w[1]    = w1;
    r.w[2]    = w2;
    r.w[3]    = w3;
    r.start_n = start_n;
    r.eodl_n  = eodl_n;
    r.rdy_pat = rp;
    r.rdy_bit = rb;
    return r;
  endfunction

  task automatic abort_run(string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_fail(string msg);
    abort_run($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
  endtask

  // one clock; read strobe and take are sampled mid-cycle where they are stable
  task automatic step_cycle();
    logic rd;
    logic tk;
    logic gap;
    @(negedge CLK);
    rd      = buf_rd;
    tk      = dl_decoder_inst.step.take;
    last_rd = rd;
    @(posedge CLK);
    #5;
    if (rd) begin
      assert (fifo.size() > 0) else check_fail("buffer read while the buffer model was empty");
      void'(fifo.pop_front());
    end
    if (tk) begin
      taken++;
    end
    if (start_blt) begin
      start_cnt++;
    end
    if (eodl) begin
      eodl_cnt++;
    end
    rnd      = next_rand(rnd);
    busy     = (rnd[2:0] == 3'd0) ? dl_pkg::busy_t'(rnd[6:4]) : '0;
    gap      = (rnd[9:8] == 2'd0);
    empty    = (fifo.size() == 0) || gap;
    buf_data = (fifo.size() > 0) ? fifo[0] : '0;
  endtask

  task automatic pulse_exe();
    exe = 1'b1;
    step_cycle();
    exe = 1'b0;
  endtask

  task automatic pulse_init();
    init = 1'b1;
    step_cycle();
    init = 1'b0;
  endtask

  // ------------------------------------------------------------
  // expected values cut from the words by field position
  // ------------------------------------------------------------
  function automatic void clear_model();
    exp_frame  = '0;
    exp_area   = '0;
    exp_fcolor = '0;
    exp_pat    = '0;
    exp_bit    = '0;
  endfunction

  function automatic void apply_model(row_t r);
    dl_pkg::opcode_t op;
    op = r.w[0][31:24];
    case (op)
      dl_pkg::OP_SETFRAME: begin
        exp_frame.vram_adr = r.w[1][22:0];
        exp_frame.width    = r.w[2][25:16];
        exp_frame.height   = r.w[2][9:0];
      end
      dl_pkg::OP_SETDRAWAREA: begin
        exp_area.pos_x = r.w[1][25:16];
        exp_area.pos_y = r.w[1][9:0];
        exp_area.siz_x = r.w[2][25:16];
        exp_area.siz_y = r.w[2][9:0];
      end
      dl_pkg::OP_SETFCOLOR: begin
        exp_fcolor = r.w[1];
      end
      dl_pkg::OP_PATBLT: begin
        exp_pat.dpos_x = r.w[1][26:16];
        exp_pat.dpos_y = r.w[1][10:0];
        exp_pat.dsiz_x = r.w[2][25:16];
        exp_pat.dsiz_y = r.w[2][9:0];
      end
      dl_pkg::OP_BITBLT: begin
        exp_bit.rect.dpos_x = r.w[1][26:16];
        exp_bit.rect.dpos_y = r.w[1][10:0];
        exp_bit.rect.dsiz_x = r.w[2][25:16];
        exp_bit.rect.dsiz_y = r.w[2][9:0];
        exp_bit.spos_x      = r.w[3][25:16];
        exp_bit.spos_y      = r.w[3][9:0];
      end
      default: begin
      end
    endcase
  endfunction

  task automatic check_outputs(row_t r, string what);
    assert (frame === exp_frame)
      else check_fail($sformatf("%s: frame %h, expected %h", what, frame, exp_frame));
    assert (draw_area === exp_area)
      else check_fail($sformatf("%s: draw_area %h, expected %h", what, draw_area, exp_area));
    assert (fcolor === exp_fcolor)
      else check_fail($sformatf("%s: fcolor %h, expected %h", what, fcolor, exp_fcolor));
    assert (pat === exp_pat)
      else check_fail($sformatf("%s: pat %h, expected %h", what, pat, exp_pat));
    assert (bit_cmd === exp_bit)
      else check_fail($sformatf("%s: bit_cmd %h, expected %h", what, bit_cmd, exp_bit));
    assert (ready_pat === r.rdy_pat && ready_bit === r.rdy_bit)
      else check_fail($sformatf("%s: ready pair %b%b, expected %b%b", what,
                                ready_pat, ready_bit, r.rdy_pat, r.rdy_bit));
    assert (start_cnt == r.start_n)
      else check_fail($sformatf("%s: %0d start pulses, expected %0d", what,
                                start_cnt, r.start_n));
    assert (eodl_cnt == r.eodl_n)
      else check_fail($sformatf("%s: %0d eodl pulses, expected %0d", what,
                                eodl_cnt, r.eodl_n));
    assert (dl_decoder_inst.dl_decoder_chk_inst.err_count == 0)
      else abort_run("the protocol checker flagged a violation");
  endtask

  task automatic push_row(row_t r);
    start_cnt = 0;
    eodl_cnt  = 0;
    taken     = 0;
    for (int i = 0; i < r.n; i++) begin
      fifo.push_back(r.w[i]);
    end
  endtask

  task automatic finish_row(row_t r, string what);
    int cnt;
    cnt = 0;
    apply_model(r);
    while (fifo.size() != 0 || taken < r.n) begin
      if (cnt == ROW_TIMEOUT) begin
        abort_run($sformatf("timeout: %s was not consumed within %0d cycles", what, cnt));
      end
      step_cycle();
      cnt++;
    end
    // outputs settle one cycle after the last take
    step_cycle();
    check_outputs(r, what);
  endtask

  // words, then start pulses, eodl pulses, ready_pat, ready_bit
  task automatic load_rows();
    rows[0]  = mk_row(3, 32'h2000_0000, 32'h0012_3456, 32'h0280_01E0, '0, 0, 0, 0, 0);
    rows[1]  = mk_row(3, 32'h2100_0000, 32'h0010_0020, 32'h0100_00C0, '0, 0, 0, 0, 0);
    rows[2]  = mk_row(2, 32'h2300_0000, 32'hCAFE_F00D, '0, '0, 0, 0, 0, 0);
    rows[3]  = mk_row(3, 32'h8100_0000, 32'h07FF_0400, 32'h0040_0030, '0, 1, 0, 1, 0);
    rows[4]  = mk_row(4, 32'h8200_0000, 32'h0005_0006, 32'h0010_0011, 32'h0123_0234,
                      1, 0, 0, 1);
    rows[5]  = mk_row(1, 32'h0000_0000, '0, '0, '0, 0, 0, 0, 1);
    // unknown code of one word
    rows[6]  = mk_row(1, 32'h5500_1234, '0, '0, '0, 0, 0, 0, 1);
    rows[7]  = mk_row(2, 32'h2300_0000, 32'h1234_5678, '0, '0, 0, 0, 0, 1);
    rows[8]  = mk_row(1, 32'h0F00_0000, '0, '0, '0, 0, 1, 0, 1);
    rows[9]  = mk_row(3, 32'h81FF_FFFF, 32'hFFFF_FFFF, 32'hFC01_FC02, '0, 1, 0, 1, 0);
    rows[10] = mk_row(3, 32'h2000_0000, 32'hFFFF_FFFF, 32'h03FF_03FF, '0, 0, 0, 1, 0);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    row_t init_row;
    row_t idle_row;
    RST_X     = 1'b0;
    init      = 1'b0;
    exe       = 1'b0;
    busy      = '0;
    buf_data  = '0;
    empty     = 1'b1;
    rnd       = 32'hda78;
    last_rd   = 1'b0;
    taken     = 0;
    start_cnt = 0;
    eodl_cnt  = 0;
    clear_model();
    load_rows();
    init_row = mk_row(2, 32'h2300_0000, 32'h00AB_CDEF, '0, '0, 0, 0, 0, 0);
    idle_row = mk_row(0, '0, '0, '0, '0, 0, 0, 0, 0);

    repeat (10) @(posedge CLK);
    #5;
    RST_X = 1'b1;
    step_cycle();
    pulse_exe();

    for (int i = 0; i < NUM_ROWS; i++) begin
      push_row(rows[i]);
      finish_row(rows[i], $sformatf("row %0d", i));
    end

    // init clears everything and drops the exe latch
    start_cnt = 0;
    eodl_cnt  = 0;
    pulse_init();
    step_cycle();
    clear_model();
    check_outputs(idle_row, "after init");

    push_row(init_row);
    for (int hold = 0; hold < 8; hold++) begin
      step_cycle();
      assert (last_rd === 1'b0) else check_fail("buf_rd high after init before exe");
    end
    pulse_exe();
    finish_row(init_row, "row after init");

    if (dl_decoder_inst.dl_decoder_chk_inst.err_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run("the protocol checker flagged a violation");
    end
  end

endmodule

//--- dl_decoder.f
hw/dl_pkg.sv
hw/dl_sequencer.sv
hw/render_state_regs.sv
hw/blit_launch.sv
hw/dl_decoder.sv
bench/dl_decoder_chk.sv
bench/dl_decoder_tb.sv

//--- Makefile
# Verilator flow for the display-list decoder

VERILATOR ?= verilator
TOP       ?= dl_decoder_tb
FILELIST  ?= dl_decoder.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
